/* design/sifhPkg.sv */
package sifhPkg;

    // timestamp from the TDC, one per wrEn cycle
    localparam int Np = 10;

    // histogram count width
    localparam int peakMax = 8;

    // top timestamp bits pick the bin
    localparam int binBits = 5;
    localparam int BIN_NUM = 2 ** binBits;

    // pixels sharing one histogram RAM
    localparam int pixelBits = 2;
    localparam int PIXEL_NUM_PER_RAM = 2 ** pixelBits;

    // frame order is pixel, then acquisition, then timestamp
    localparam int ACQ_NUM = 4;
    localparam int DATA_NUM = 2;

    // 8 samples per pixel, so an 8-bit count never overflows
    localparam int SAMPLES_PER_PIXEL = ACQ_NUM * DATA_NUM;
    localparam int SAMPLES_PER_FRAME = PIXEL_NUM_PER_RAM * SAMPLES_PER_PIXEL;

    // one word per bin per pixel
    localparam int Nb = pixelBits + binBits;

    // histogram RAM address
    // flat view for the linear scan sweep
    // split view for composing and reporting pixel and bin
    typedef union packed {
        logic [Nb-1:0] flat;
        struct packed {
            logic [pixelBits-1:0] pixel;
            logic [binBits-1:0]   bin;
        } fields;
    } histAddrT;

endpackage

/* design/histUpdateFsm.sv */
`timescale 1ns/1ps

module histUpdateFsm (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        wrEn,
    input  logic [sifhPkg::Np-1:0]      data,
    input  logic [sifhPkg::peakMax-1:0] counts,
    input  logic                        scanBusy,
    output sifhPkg::histAddrT           raddr,
    output sifhPkg::histAddrT           waddr,
    output logic                        rEnable,
    output logic                        wEnable,
    output logic [sifhPkg::peakMax-1:0] newCounts,
    output logic                        frameDone,
    output logic                        busy
);
    import sifhPkg::*;

    // position of the incoming sample inside the frame
    logic [$clog2(DATA_NUM)-1:0] dataCnt;
    logic [$clog2(ACQ_NUM)-1:0]  acqCnt;
    logic [pixelBits-1:0]        pixelCnt;

    logic accept;
    logic lastSample;
    // frame fully written, waiting for the scanner to take over
    logic pendingScan;

    // write-stage sample reads the word the previous write just updated
    logic               fwdHit;
    logic [peakMax-1:0] fwdCount;

    // input is dropped while a scan is pending or running
    assign busy   = pendingScan | scanBusy;
    assign accept = wrEn & ~busy;

    assign lastSample = (int'(pixelCnt) == PIXEL_NUM_PER_RAM - 1) &&
                        (int'(acqCnt) == ACQ_NUM - 1) &&
                        (int'(dataCnt) == DATA_NUM - 1);

    // read stage, issued on the accepting edge
    always_comb begin
        raddr.fields.pixel = pixelCnt;
        raddr.fields.bin   = data[Np-1 -: binBits];
    end
    assign rEnable = accept;

    // write stage, old count or forwarded count plus one
    assign newCounts = (fwdHit ? fwdCount : counts) + peakMax'(1);

    // frame position counters
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dataCnt  <= '0;
            acqCnt   <= '0;
            pixelCnt <= '0;
        end else if (accept) begin
            if (int'(dataCnt) == DATA_NUM - 1) begin
                dataCnt <= '0;
                if (int'(acqCnt) == ACQ_NUM - 1) begin
                    acqCnt <= '0;
                    // wraps to pixel 0 after the last pixel
                    pixelCnt <= pixelCnt + 1'b1;
                end else begin
                    acqCnt <= acqCnt + 1'b1;
                end
            end else begin
                dataCnt <= dataCnt + 1'b1;
            end
        end
    end

    // pipeline control and frame handoff
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wEnable     <= 1'b0;
            frameDone   <= 1'b0;
            pendingScan <= 1'b0;
        end else begin
            wEnable   <= accept;
            // coincides with the write of sample 32
            frameDone <= accept & lastSample;
            if (accept && lastSample) begin
                pendingScan <= 1'b1;
            end else if (frameDone) begin
                // scanBusy holds busy from the next cycle on
                pendingScan <= 1'b0;
            end
        end
    end

    // write-stage payload
    always_ff @(posedge clk) begin
        if (accept) begin
            waddr    <= raddr;
            // RAM returns the pre-write value on a same-edge collision
            fwdHit   <= wEnable && (raddr.flat == waddr.flat);
            fwdCount <= newCounts;
        end
    end

endmodule

/* design/histRam.sv */
`timescale 1ns/1ps

module histRam (
    input  logic                        clk,
    input  sifhPkg::histAddrT           raddr,
    input  logic                        rEnable,
    input  sifhPkg::histAddrT           waddr,
    input  logic                        wEnable,
    input  logic [sifhPkg::peakMax-1:0] newCounts,
    input  sifhPkg::histAddrT           scanAddr,
    input  logic                        scanEn,
    output logic [sifhPkg::peakMax-1:0] counts,
    output logic [sifhPkg::peakMax-1:0] scanCounts
);
    import sifhPkg::*;

    // one word per bin of every pixel
    logic [peakMax-1:0] mem [PIXEL_NUM_PER_RAM * BIN_NUM];

    // empty histograms at power-up
    initial begin
        for (int i = 0; i < PIXEL_NUM_PER_RAM * BIN_NUM; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        // update port read, old data on a same-address write
        if (rEnable) begin
            counts <= mem[raddr.flat];
        end
        // scan port read
        if (scanEn) begin
            scanCounts <= mem[scanAddr.flat];
        end
        // update and scan never overlap since busy blocks input
        if (wEnable) begin
            mem[waddr.flat] <= newCounts;
        end else if (scanEn) begin
            // read-and-clear for the next frame
            mem[scanAddr.flat] <= '0;
        end
    end

endmodule

/* design/peakScan.sv */
`timescale 1ns/1ps

module peakScan (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          frameDone,
    input  logic [sifhPkg::peakMax-1:0]   scanCounts,
    output sifhPkg::histAddrT             scanAddr,
    output logic                          scanEn,
    output logic                          scanBusy,
    output logic                          peakValid,
    output logic [sifhPkg::pixelBits-1:0] peakPixel,
    output logic [sifhPkg::binBits-1:0]   peakBin,
    output logic [sifhPkg::peakMax-1:0]   peakCount
);
    import sifhPkg::*;

    // address of the word now on scanCounts
    histAddrT dataAddr;
    logic     dataValid;

    // running peak of the current pixel
    logic [peakMax-1:0] maxCount;
    logic [binBits-1:0] maxBin;

    logic               takeNew;
    logic               pixelEnd;
    logic [peakMax-1:0] bestCount;
    logic [binBits-1:0] bestBin;

    // bin 0 restarts the pixel, strict compare keeps the lowest bin on ties
    assign takeNew   = (dataAddr.fields.bin == '0) || (scanCounts > maxCount);
    assign bestCount = takeNew ? scanCounts : maxCount;
    assign bestBin   = takeNew ? dataAddr.fields.bin : maxBin;
    assign pixelEnd  = dataValid && (int'(dataAddr.fields.bin) == BIN_NUM - 1);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            scanAddr  <= '0;
            scanEn    <= 1'b0;
            scanBusy  <= 1'b0;
            dataValid <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            dataValid <= scanEn;
            peakValid <= pixelEnd;
            if (frameDone) begin
                // sweep starts next cycle from word 0
                scanAddr <= '0;
                scanEn   <= 1'b1;
                scanBusy <= 1'b1;
            end else begin
                if (scanEn) begin
                    scanAddr.flat <= scanAddr.flat + 1'b1;
                    // last word issued
                    if (int'(scanAddr.flat) == PIXEL_NUM_PER_RAM * BIN_NUM - 1) begin
                        scanEn <= 1'b0;
                    end
                end
                // drop after the last pixel has been reported
                if (peakValid && int'(peakPixel) == PIXEL_NUM_PER_RAM - 1) begin
                    scanBusy <= 1'b0;
                end
            end
        end
    end

    // peak tracking and result registers
    always_ff @(posedge clk) begin
        dataAddr <= scanAddr;
        if (dataValid) begin
            maxCount <= bestCount;
            maxBin   <= bestBin;
        end
        if (pixelEnd) begin
            peakPixel <= dataAddr.fields.pixel;
            peakBin   <= bestBin;
            peakCount <= bestCount;
        end
    end

endmodule

/* design/sifhTop.sv */
`timescale 1ns/1ps

module sifhTop (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          wrEn,
    input  logic [sifhPkg::Np-1:0]        data,
    output logic                          busy,
    output logic                          peakValid,
    output logic [sifhPkg::pixelBits-1:0] peakPixel,
    output logic [sifhPkg::binBits-1:0]   peakBin,
    output logic [sifhPkg::peakMax-1:0]   peakCount
);
    import sifhPkg::*;

    // update port
    histAddrT           raddr;
    histAddrT           waddr;
    logic               rEnable;
    logic               wEnable;
    logic [peakMax-1:0] counts;
    logic [peakMax-1:0] newCounts;

    // scan port
    histAddrT           scanAddr;
    logic               scanEn;
    logic [peakMax-1:0] scanCounts;

    // frame handoff
    logic frameDone;
    logic scanBusy;

    histUpdateFsm u_histUpdateFsm (
        .clk       (clk),
        .rstN      (rstN),
        .wrEn      (wrEn),
        .data      (data),
        .counts    (counts),
        .scanBusy  (scanBusy),
        .raddr     (raddr),
        .waddr     (waddr),
        .rEnable   (rEnable),
        .wEnable   (wEnable),
        .newCounts (newCounts),
        .frameDone (frameDone),
        .busy      (busy)
    );

    histRam u_histRam (
        .clk        (clk),
        .raddr      (raddr),
        .rEnable    (rEnable),
        .waddr      (waddr),
        .wEnable    (wEnable),
        .newCounts  (newCounts),
        .scanAddr   (scanAddr),
        .scanEn     (scanEn),
        .counts     (counts),
        .scanCounts (scanCounts)
    );

    peakScan u_peakScan (
        .clk        (clk),
        .rstN       (rstN),
        .frameDone  (frameDone),
        .scanCounts (scanCounts),
        .scanAddr   (scanAddr),
        .scanEn     (scanEn),
        .scanBusy   (scanBusy),
        .peakValid  (peakValid),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

endmodule

/* dv/sifhTb.sv */
`timescale 1ns/1ps

module sifhTb;
    import sifhPkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 20;
    // samples, random gaps and the 130-cycle sweep
    localparam int FRAME_CYCLES = 250;
    localparam int NUM_FRAMES   = 6;
    localparam int TIMEOUT_CYCLES = 2 * NUM_FRAMES * FRAME_CYCLES;

    logic                 clk;
    logic                 rstN;
    logic                 wrEn;
    logic [Np-1:0]        data;
    logic                 busy;
    logic                 peakValid;
    logic [pixelBits-1:0] peakPixel;
    logic [binBits-1:0]   peakBin;
    logic [peakMax-1:0]   peakCount;

    int          cycleCnt = 0;
    int          errorCount;
    logic [31:0] lcgState;

    // one frame of stimulus, pixel-major
    logic [Np-1:0] stimTs [SAMPLES_PER_FRAME];
    int            stimGap [SAMPLES_PER_FRAME];
    // reference histogram of the current frame
    int            refHist [PIXEL_NUM_PER_RAM][BIN_NUM];

    sifhTop u_dut (
        .clk       (clk),
        .rstN      (rstN),
        .wrEn      (wrEn),
        .data      (data),
        .busy      (busy),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // edge counter and run limit
    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, peak results never completed", cycleCnt);
            $display("errors: %0d", errorCount + 1);
            $display("Verification failed");
            $finish;
        end
    end

    function logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // bin in the top bits, filler below
    function automatic logic [Np-1:0] makeTs(input int bin, input int low);
        return {binBits'(bin), (Np - binBits)'(low)};
    endfunction

    task automatic checkValue(input string testName, input string what,
                              input int expected, input int actual);
        assert (expected == actual) else begin
            errorCount++;
            $display("MISMATCH %s %s: expected %0d, actual %0d",
                     testName, what, expected, actual);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #0.5;
    endtask

    // strictly greater keeps the lowest bin on ties
    task automatic modelPeak(input int pixel, output int bin, output int count);
        bin = 0;
        count = refHist[pixel][0];
        for (int b = 1; b < BIN_NUM; b++) begin
            if (refHist[pixel][b] > count) begin
                bin = b;
                count = refHist[pixel][b];
            end
        end
    endtask

    // feed stimTs with stimGap idles, then check the four peak pulses
    task automatic runFrame(input string testName, input bit checkPeaks);
        int lastAccept;
        int expBin;
        int expCount;
        lastAccept = 0;
        foreach (refHist[p, b]) begin
            refHist[p][b] = 0;
        end
        for (int s = 0; s < SAMPLES_PER_FRAME; s++) begin
            if (stimGap[s] > 0) begin
                wrEn = 1'b0;
                repeat (stimGap[s]) nextCycle();
            end
            checkValue(testName, "busy before sample", 0, int'(busy));
            wrEn = 1'b1;
            data = stimTs[s];
            refHist[s / SAMPLES_PER_PIXEL][stimTs[s][Np-1 -: binBits]]++;
            // taken on the coming edge
            lastAccept = cycleCnt + 1;
            nextCycle();
        end
        wrEn = 1'b0;
        data = '0;
        for (int p = 0; p < PIXEL_NUM_PER_RAM; p++) begin
            @(negedge clk);
            while (!peakValid) @(negedge clk);
            modelPeak(p, expBin, expCount);
            checkValue(testName, "peakPixel", p, int'(peakPixel));
            // sweep starts on the write edge of the last sample
            checkValue(testName, "pulse cycle", lastAccept + 1 + BIN_NUM * (p + 1) + 1,
                       cycleCnt);
            checkValue(testName, "busy during scan", 1, int'(busy));
            if (checkPeaks) begin
                checkValue(testName, "peakBin", expBin, int'(peakBin));
                checkValue(testName, "peakCount", expCount, int'(peakCount));
            end
        end
        // last pulse ends 130 cycles after the write, busy with it
        @(negedge clk);
        checkValue(testName, "peakValid after last pulse", 0, int'(peakValid));
        checkValue(testName, "busy after last pulse", 0, int'(busy));
        nextCycle();
    endtask

    task automatic idleAfterReset();
        repeat (IDLE_CYCLES) begin
            checkValue("idleAfterReset", "busy", 0, int'(busy));
            checkValue("idleAfterReset", "peakValid", 0, int'(peakValid));
            nextCycle();
        end
    endtask

    // flushes whatever the RAM holds, peaks not checked
    task automatic clearRam();
        logic [31:0] r;
        for (int s = 0; s < SAMPLES_PER_FRAME; s++) begin
            r = nextRand();
            stimTs[s] = r[31 -: Np];
            stimGap[s] = 0;
        end
        runFrame("clearRam", 1'b0);
    endtask

    // pixel p gets p+3 hits on one bin, single hits elsewhere
    task automatic directedPeaks();
        int pb;
        int k;
        for (int s = 0; s < SAMPLES_PER_FRAME; s++) begin
            pb = 5 + 7 * (s / SAMPLES_PER_PIXEL);
            k = s % SAMPLES_PER_PIXEL;
            if (k < s / SAMPLES_PER_PIXEL + 3) begin
                stimTs[s] = makeTs(pb, k * 7 + 1);
            end else begin
                stimTs[s] = makeTs((pb + 1 + k) % BIN_NUM, k * 7 + 1);
            end
            stimGap[s] = s % 2;
        end
        runFrame("directedPeaks", 1'b1);
    endtask

    // all 8 samples of a pixel on one bin, wrEn high for the whole frame
    task automatic sameBinForwarding();
        for (int s = 0; s < SAMPLES_PER_FRAME; s++) begin
            stimTs[s] = makeTs(30 - 9 * (s / SAMPLES_PER_PIXEL), s);
            stimGap[s] = 0;
        end
        runFrame("sameBinForwarding", 1'b1);
    endtask

    // 4 and 4 hits on two bins, higher bin fed first
    task automatic tieLowestBin();
        int p;
        for (int s = 0; s < SAMPLES_PER_FRAME; s++) begin
            p = s / SAMPLES_PER_PIXEL;
            if (s % SAMPLES_PER_PIXEL < SAMPLES_PER_PIXEL / 2) begin
                stimTs[s] = makeTs(17 + 4 * p, s);
            end else begin
                stimTs[s] = makeTs(2 + 3 * p, s);
            end
            stimGap[s] = (s % 3 == 0) ? 1 : 0;
        end
        runFrame("tieLowestBin", 1'b1);
    endtask

    // same samples again, counts left over from the last frame would double
    task automatic secondFrame();
        runFrame("secondFrame", 1'b1);
    endtask

    // LCG timestamps, 0 to 3 idle cycles before each sample
    task automatic randomFrame();
        logic [31:0] r;
        for (int s = 0; s < SAMPLES_PER_FRAME; s++) begin
            r = nextRand();
            stimTs[s] = r[31 -: Np];
            r = nextRand();
            stimGap[s] = int'(r[31:30]);
        end
        runFrame("randomFrame", 1'b1);
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        wrEn = 1'b0;
        data = '0;
        errorCount = 0;
        lcgState = 32'h82032d62;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rstN = 1'b1;
        idleAfterReset();
        clearRam();
        directedPeaks();
        sameBinForwarding();
        tieLowestBin();
        secondFrame();
        randomFrame();
        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/sifhPkg.sv
design/histUpdateFsm.sv
design/histRam.sv
design/peakScan.sv
design/sifhTop.sv
dv/sifhTb.sv

/* Makefile */
# Verilator flow for the histogram subsystem

VERILATOR ?= verilator
TOP       ?= sifhTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  build  compile $(TOP) from $(FILELIST) into $(BUILD_DIR)"
	@echo "  test   build, run the simulation into $(LOG), check for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "test failed, see $(LOG)"; exit 1; }
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
